/* common/videoPkg.sv */
//------------------------------
// Video transmitter shared types
// Raster timing, register map and bus structs
//------------------------------
package videoPkg;

	//------------------------------
	// Vector types
	//------------------------------
	// 24 bit RGB, red in the top byte
	typedef logic [23:0] colorT;
	// Pixel coordinate
	typedef logic [7:0] posT;
	typedef logic [7:0] csrAdrsT;
	typedef logic [31:0] csrDataT;

	//------------------------------
	// Raster timing
	//------------------------------
	// Horizontal in pixel clocks
	localparam int lpHActive = 16;
	localparam int lpHFront = 2;
	localparam int lpHSync = 3;
	localparam int lpHBack = 3;
	localparam int lpHTotal = lpHActive + lpHFront + lpHSync + lpHBack;
	// Vertical in lines
	localparam int lpVActive = 8;
	localparam int lpVFront = 1;
	localparam int lpVSync = 2;
	localparam int lpVBack = 2;
	localparam int lpVTotal = lpVActive + lpVFront + lpVSync + lpVBack;

	// Idle cycles before the raster starts after reset
	localparam int lpRstWait = 16;
	// Painter depth, matched by the mixer delay line
	localparam int lpPaintLatency = 2;
	localparam int lpSquareNum = 4;

	//------------------------------
	// Register map
	//------------------------------
	localparam csrAdrsT lpAdrsCtrl = 8'h00;
	localparam csrAdrsT lpAdrsTft = 8'h01;
	localparam csrAdrsT lpAdrsBack = 8'h02;
	// One word per square from these bases
	localparam csrAdrsT lpAdrsColorBase = 8'h10;
	localparam csrAdrsT lpAdrsBoundBase = 8'h20;
	localparam csrAdrsT lpAdrsStatus = 8'h30;

	// Raster sample, fe pulses at the first active pixel of a frame
	typedef struct packed {
		logic hs;
		logic vs;
		logic de;
		logic fe;
		posT hpos;
		posT vpos;
	} rasterT;

	// Inside when left <= hpos < right and top <= vpos < under
	typedef struct packed {
		colorT color;
		posT left;
		posT right;
		posT top;
		posT under;
	} squareT;

	// Panel command lines
	typedef struct packed {
		logic [7:0] data;
		logic rst;
		logic wr;
		logic rd;
		logic rs;
		logic cs;
	} tftCmdT;

	// Single cycle write strobe
	typedef struct packed {
		logic we;
		csrAdrsT adrs;
		csrDataT wd;
	} csrWriteT;

	typedef enum logic [1:0] {
		waitRst,
		run,
		hold
	} syncStateT;

endpackage

/* logic/videoCsr.sv */
//------------------------------
// Video register file
// Strobe writes, registered readback and position status
//------------------------------
`timescale 1ns/1ps

module videoCsr (
	input  logic                                           iVCLK,
	input  logic                                           iVRST,
	input  videoPkg::csrWriteT                             csrWr,
	input  videoPkg::csrAdrsT                              csrRdAdrs,
	output videoPkg::csrDataT                              csrRd,
	input  videoPkg::rasterT                               raster,
	output videoPkg::squareT [videoPkg::lpSquareNum-1:0]   squares,
	output videoPkg::colorT                                backColor,
	output videoPkg::tftCmdT                               tftCmd,
	output logic                                           tftGate,
	output logic                                           syncHold
);

	videoPkg::csrDataT rdMux;

	//------------------------------
	// Write decode
	//------------------------------
	// Ctrl bit 0 holds the raster, bit 1 hands the pins to the panel command
	// Tft word is data in [7:0] then rst wr rd rs cs from bit 8
	// Bound word is left right top under from the low byte up
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			syncHold <= 1'b0;
			tftGate <= 1'b0;
			// Panel held in reset and deselected
			tftCmd <= '{data: 8'd0, rst: 1'b1, wr: 1'b0, rd: 1'b0, rs: 1'b0, cs: 1'b1};
			backColor <= '0;
			// Zero bounds leave every square empty
			squares <= '0;
		end
		else if (csrWr.we)
		begin
			case (csrWr.adrs)
				videoPkg::lpAdrsCtrl:
				begin
					syncHold <= csrWr.wd[0];
					tftGate <= csrWr.wd[1];
				end
				videoPkg::lpAdrsTft:
				begin
					tftCmd.data <= csrWr.wd[7:0];
					tftCmd.rst <= csrWr.wd[8];
					tftCmd.wr <= csrWr.wd[9];
					tftCmd.rd <= csrWr.wd[10];
					tftCmd.rs <= csrWr.wd[11];
					tftCmd.cs <= csrWr.wd[12];
				end
				videoPkg::lpAdrsBack:
					backColor <= csrWr.wd[23:0];
				default:
				begin
				end
			endcase
			// Per square words
			for (int i = 0; i < videoPkg::lpSquareNum; i++)
			begin
				if (csrWr.adrs == videoPkg::lpAdrsColorBase + videoPkg::csrAdrsT'(i))
				begin
					squares[i].color <= csrWr.wd[23:0];
				end
				if (csrWr.adrs == videoPkg::lpAdrsBoundBase + videoPkg::csrAdrsT'(i))
				begin
					squares[i].left <= csrWr.wd[7:0];
					squares[i].right <= csrWr.wd[15:8];
					squares[i].top <= csrWr.wd[23:16];
					squares[i].under <= csrWr.wd[31:24];
				end
			end
		end
	end

	//------------------------------
	// Readback
	//------------------------------
	always_comb
	begin
		rdMux = '0;
		case (csrRdAdrs)
			videoPkg::lpAdrsCtrl:
				rdMux = {30'd0, tftGate, syncHold};
			videoPkg::lpAdrsTft:
				rdMux = {19'd0, tftCmd.cs, tftCmd.rs, tftCmd.rd, tftCmd.wr, tftCmd.rst,
					tftCmd.data};
			videoPkg::lpAdrsBack:
				rdMux = {8'd0, backColor};
			// Live raster position, vpos above hpos
			videoPkg::lpAdrsStatus:
				rdMux = {16'd0, raster.vpos, raster.hpos};
			default:
				rdMux = '0;
		endcase
		for (int i = 0; i < videoPkg::lpSquareNum; i++)
		begin
			if (csrRdAdrs == videoPkg::lpAdrsColorBase + videoPkg::csrAdrsT'(i))
				rdMux = {8'd0, squares[i].color};
			if (csrRdAdrs == videoPkg::lpAdrsBoundBase + videoPkg::csrAdrsT'(i))
				rdMux = {squares[i].under, squares[i].top, squares[i].right, squares[i].left};
		end
	end

	// One cycle read latency
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			csrRd <= '0;
		else
			csrRd <= rdMux;
	end

endmodule

/* videoSync/videoSyncGen.sv */
//------------------------------
// Raster timing generator
// HS VS DE FE and pixel position after a reset wait
//------------------------------
`timescale 1ns/1ps

module videoSyncGen (
	input  logic             iVCLK,
	input  logic             iVRST,
	input  logic             syncHold,
	output videoPkg::rasterT raster
);

	videoPkg::syncStateT state;
	logic [$clog2(videoPkg::lpRstWait)-1:0] waitCnt;
	// Position currently on the raster outputs
	videoPkg::posT hCnt;
	videoPkg::posT vCnt;
	videoPkg::posT hNext;
	videoPkg::posT vNext;

	//------------------------------
	// Region decode
	//------------------------------
	// Active, front porch, sync, back porch in both directions
	function automatic videoPkg::rasterT decodeRaster(
		input videoPkg::posT h,
		input videoPkg::posT v
	);
		videoPkg::rasterT r;
		r.hpos = h;
		r.vpos = v;
		r.de = (h < videoPkg::lpHActive) && (v < videoPkg::lpVActive);
		// First active pixel of the frame
		r.fe = (h == '0) && (v == '0);
		r.hs = (h >= videoPkg::lpHActive + videoPkg::lpHFront)
			&& (h < videoPkg::lpHActive + videoPkg::lpHFront + videoPkg::lpHSync);
		r.vs = (v >= videoPkg::lpVActive + videoPkg::lpVFront)
			&& (v < videoPkg::lpVActive + videoPkg::lpVFront + videoPkg::lpVSync);
		return r;
	endfunction

	// Next position with line and frame wrap
	always_comb
	begin
		hNext = hCnt + 1'b1;
		vNext = vCnt;
		if (hCnt == videoPkg::posT'(videoPkg::lpHTotal - 1))
		begin
			hNext = '0;
			if (vCnt == videoPkg::posT'(videoPkg::lpVTotal - 1))
				vNext = '0;
			else
				vNext = vCnt + 1'b1;
		end
	end

	//------------------------------
	// State machine and counters
	//------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			state <= videoPkg::waitRst;
			waitCnt <= '0;
			hCnt <= '0;
			vCnt <= '0;
			raster <= '0;
		end
		else
		begin
			case (state)
				videoPkg::waitRst:
				begin
					waitCnt <= waitCnt + 1'b1;
					// Last wait cycle, raster starts at 0,0 on the next one
					if (waitCnt == ($bits(waitCnt))'(videoPkg::lpRstWait - 1))
					begin
						if (syncHold)
						begin
							state <= videoPkg::hold;
						end
						else
						begin
							state <= videoPkg::run;
							raster <= decodeRaster('0, '0);
						end
					end
				end
				videoPkg::run:
				begin
					if (syncHold)
					begin
						state <= videoPkg::hold;
						hCnt <= '0;
						vCnt <= '0;
						raster <= '0;
					end
					else
					begin
						hCnt <= hNext;
						vCnt <= vNext;
						raster <= decodeRaster(hNext, vNext);
					end
				end
				videoPkg::hold:
				begin
					// Counters already cleared, restart with a fresh frame
					if (!syncHold)
					begin
						state <= videoPkg::run;
						raster <= decodeRaster('0, '0);
					end
				end
				default:
					state <= videoPkg::waitRst;
			endcase
		end
	end

endmodule

/* videoPaint/videoSquarePainter.sv */
//------------------------------
// Square painter
// Two stage hit test and priority color select
//------------------------------
`timescale 1ns/1ps

module videoSquarePainter (
	input  logic                                         iVCLK,
	input  logic                                         iVRST,
	input  videoPkg::rasterT                             raster,
	input  videoPkg::squareT [videoPkg::lpSquareNum-1:0] squares,
	input  videoPkg::colorT                              backColor,
	output videoPkg::colorT                              pixel
);

	// Hit per square for the current raster position
	logic [videoPkg::lpSquareNum-1:0] hit;

	// Stage one registers
	logic [videoPkg::lpSquareNum-1:0] hitS1;
	videoPkg::colorT [videoPkg::lpSquareNum-1:0] colorS1;
	videoPkg::colorT backS1;
	logic deS1;

	// Stage two select
	videoPkg::colorT selColor;

	//------------------------------
	// Stage one, hit test
	//------------------------------
	// Half open bounds, an empty square never hits
	always_comb
	begin
		for (int i = 0; i < videoPkg::lpSquareNum; i++)
		begin
			hit[i] = (raster.hpos >= squares[i].left)
				&& (raster.hpos < squares[i].right)
				&& (raster.vpos >= squares[i].top)
				&& (raster.vpos < squares[i].under);
		end
	end

	// Colors travel with the hits so a mid frame write stays pixel aligned
	always_ff @(posedge iVCLK)
	begin
		hitS1 <= hit;
		backS1 <= backColor;
		for (int i = 0; i < videoPkg::lpSquareNum; i++)
		begin
			colorS1[i] <= squares[i].color;
		end
	end

	// Active flag for blanking in stage two
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
			deS1 <= 1'b0;
		else
			deS1 <= raster.de;
	end

	//------------------------------
	// Stage two, priority select
	//------------------------------
	// Walk from the top index down so square 0 wins
	always_comb
	begin
		selColor = backS1;
		for (int i = videoPkg::lpSquareNum - 1; i >= 0; i--)
		begin
			if (hitS1[i])
				selColor = colorS1[i];
		end
	end

	// Black outside the active area
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			pixel <= '0;
		end
		else
		begin
			if (deS1)
				pixel <= selColor;
			else
				pixel <= '0;
		end
	end

endmodule

/* logic/videoOutMixer.sv */
//------------------------------
// Video output mixer
// Aligns timing to the pixel, selects the panel command
//------------------------------
`timescale 1ns/1ps

module videoOutMixer (
	input  logic             iVCLK,
	input  logic             iVRST,
	input  videoPkg::rasterT raster,
	input  videoPkg::colorT  pixel,
	input  videoPkg::tftCmdT tftCmd,
	input  logic             tftGate,
	output videoPkg::colorT  videoDq,
	output logic             videoHs,
	output logic             videoVs,
	output logic             videoDe,
	output logic             videoFe,
	output logic             videoRst,
	output logic             videoWr,
	output logic             videoRd,
	output logic             videoRs,
	output logic             videoCs
);

	// hs vs de fe per stage, index 0 is the newest
	logic [videoPkg::lpPaintLatency-1:0][3:0] syncDly;

	//------------------------------
	// Timing delay line
	//------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			syncDly <= '0;
		end
		else
		begin
			syncDly[0] <= {raster.hs, raster.vs, raster.de, raster.fe};
			for (int i = 1; i < videoPkg::lpPaintLatency; i++)
			begin
				syncDly[i] <= syncDly[i-1];
			end
		end
	end

	assign {videoHs, videoVs, videoDe, videoFe} = syncDly[videoPkg::lpPaintLatency-1];

	//------------------------------
	// Pin select
	//------------------------------
	// Command byte sits in the low lane of the bus
	assign videoDq = tftGate ? {16'd0, tftCmd.data} : pixel;
	// Bus strobes idle and panel deselected while streaming pixels
	assign videoWr = tftGate ? tftCmd.wr : 1'b0;
	assign videoRd = tftGate ? tftCmd.rd : 1'b0;
	assign videoRs = tftGate ? tftCmd.rs : 1'b0;
	assign videoCs = tftGate ? tftCmd.cs : 1'b1;
	// Panel reset is never gated
	assign videoRst = tftCmd.rst;

endmodule

/* logic/videoTx.sv */
//------------------------------
// Video transmitter top
//------------------------------
`timescale 1ns/1ps

module videoTx (
	input  logic               iVCLK,
	input  logic               iVRST,
	input  videoPkg::csrWriteT csrWr,
	input  videoPkg::csrAdrsT  csrRdAdrs,
	output videoPkg::csrDataT  csrRd,
	output videoPkg::colorT    videoDq,
	output logic               videoHs,
	output logic               videoVs,
	output logic               videoDe,
	output logic               videoFe,
	output logic               videoRst,
	output logic               videoWr,
	output logic               videoRd,
	output logic               videoRs,
	output logic               videoCs
);

	videoPkg::rasterT raster;
	videoPkg::squareT [videoPkg::lpSquareNum-1:0] squares;
	videoPkg::colorT backColor;
	videoPkg::colorT pixel;
	videoPkg::tftCmdT tftCmd;
	logic tftGate;
	logic syncHold;

	// Registers
	videoCsr csr (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.csrWr(csrWr),          .csrRdAdrs(csrRdAdrs),      .csrRd(csrRd),
		.raster(raster),        .squares(squares),          .backColor(backColor),
		.tftCmd(tftCmd),        .tftGate(tftGate),          .syncHold(syncHold)
	);

	// Raster timing
	videoSyncGen syncGen (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.syncHold(syncHold),    .raster(raster)
	);

	// Pixel branch
	videoSquarePainter painter (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.raster(raster),        .squares(squares),
		.backColor(backColor),  .pixel(pixel)
	);

	// Timing branch joins the pixel here
	videoOutMixer mixer (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.raster(raster),        .pixel(pixel),
		.tftCmd(tftCmd),        .tftGate(tftGate),
		.videoDq(videoDq),
		.videoHs(videoHs),      .videoVs(videoVs),
		.videoDe(videoDe),      .videoFe(videoFe),
		.videoRst(videoRst),    .videoWr(videoWr),          .videoRd(videoRd),
		.videoRs(videoRs),      .videoCs(videoCs)
	);

endmodule

/* test/videoTxChecker.sv */
//------------------------------
// Video transmitter checker
// Register image, raster geometry and pixel model
//------------------------------
`timescale 1ns/1ps

module videoTxChecker (
	input  logic               iVCLK,
	input  logic               iVRST,
	input  videoPkg::csrWriteT csrWr,
	input  videoPkg::csrDataT  csrRd,
	input  logic               rdReq,
	input  videoPkg::csrDataT  rdExp,
	input  logic [127:0]       testName,
	input  videoPkg::colorT    videoDq,
	input  logic               videoHs,
	input  logic               videoVs,
	input  logic               videoDe,
	input  logic               videoFe,
	input  logic               videoRst,
	input  logic               videoWr,
	input  logic               videoRd,
	input  logic               videoRs,
	input  logic               videoCs,
	output int                 errCount,
	output int                 checkCount
);

	int errs = 0;
	int checks = 0;

	// Register image built from the observed writes
	videoPkg::squareT [videoPkg::lpSquareNum-1:0] imgSq;
	videoPkg::colorT imgBack;
	videoPkg::tftCmdT imgTft;
	logic imgGate;
	logic imgHold;

	// Raster tracking
	int resetAge;
	int holdAge;
	int hCur;
	int vCur;
	int lineCnt;
	int hsLen;
	int vsLen;
	logic trackValid;
	logic expectFe;
	logic deLast;
	logic hsLast;
	logic vsLast;
	logic rdPend;
	videoPkg::csrDataT rdExpQ;

	assign errCount = errs;
	assign checkCount = checks;

	task automatic compare(input string what, input logic [31:0] expV, input logic [31:0] actV);
		checks++;
		if (expV !== actV)
		begin
			errs++;
			$display("[ERROR] %s %s: expected %h, actual %h", testName, what, expV, actV);
		end
	endtask

	task automatic fault(input string what);
		errs++;
		$display("%s: %s", testName, what);
	endtask

	// Lowest index square holding the position wins
	function automatic videoPkg::colorT expectPixel(input int h, input int v);
		videoPkg::colorT c;
		logic found;
		c = imgBack;
		found = 1'b0;
		for (int i = 0; i < videoPkg::lpSquareNum; i++)
		begin
			if (!found && h >= imgSq[i].left && h < imgSq[i].right
				&& v >= imgSq[i].top && v < imgSq[i].under)
			begin
				c = imgSq[i].color;
				found = 1'b1;
			end
		end
		return c;
	endfunction

	//------------------------------
	// Pin and readback checks
	//------------------------------
	task automatic checkPins;
		if (imgGate)
		begin
			compare("videoDq command", {16'd0, imgTft.data}, videoDq);
			compare("wr rd rs cs", {imgTft.wr, imgTft.rd, imgTft.rs, imgTft.cs},
				{videoWr, videoRd, videoRs, videoCs});
		end
		else
		begin
			// Strobes idle, panel deselected
			compare("wr rd rs cs idle", 4'b0001, {videoWr, videoRd, videoRs, videoCs});
			if (!videoDe)
				compare("videoDq blank", 32'd0, videoDq);
		end
		compare("videoRst", imgTft.rst, videoRst);
		if (rdPend)
			compare("readback", rdExpQ, csrRd);
		rdPend = rdReq;
		rdExpQ = rdExp;
	endtask

	//------------------------------
	// Raster geometry and painting
	//------------------------------
	task automatic checkRaster;
		if ((videoHs || videoVs || videoDe || videoFe) && resetAge <= videoPkg::lpRstWait)
			fault("raster active before the post reset wait ended");
		// Outputs need a few cycles to drain into hold
		if (imgHold)
		begin
			holdAge++;
			if (holdAge > 4 && (videoHs || videoVs || videoDe || videoFe))
				fault("raster active while sync hold is set");
		end
		else
			holdAge = 0;
		if (videoFe)
		begin
			if (!videoDe)
				fault("fe pulse without de");
			if (trackValid)
				compare("active lines", videoPkg::lpVActive, lineCnt);
			trackValid = 1'b1;
			hCur = 0;
			vCur = 0;
			lineCnt = 0;
		end
		if (videoDe && expectFe)
		begin
			if (!videoFe)
				fault("first de after sync hold came without fe");
			expectFe = 1'b0;
		end
		if (videoDe)
		begin
			if (trackValid && !imgGate)
				compare("pixel", expectPixel(hCur, vCur), videoDq);
			hCur++;
		end
		else if (deLast)
		begin
			if (trackValid)
				compare("de per line", videoPkg::lpHActive, hCur);
			hCur = 0;
			vCur++;
			lineCnt++;
		end
		// Sync widths, hs in cycles and vs in whole lines
		if (videoHs)
			hsLen++;
		else if (hsLast)
		begin
			if (trackValid)
				compare("hs width", videoPkg::lpHSync, hsLen);
			hsLen = 0;
		end
		if (videoVs)
			vsLen++;
		else if (vsLast)
		begin
			if (trackValid)
				compare("vs width", videoPkg::lpVSync * videoPkg::lpHTotal, vsLen);
			vsLen = 0;
		end
		deLast = videoDe;
		hsLast = videoHs;
		vsLast = videoVs;
	endtask

	// Image follows the write one cycle ahead of the DUT registers
	task automatic applyWrite;
		if (csrWr.we)
		begin
			trackValid = 1'b0;
			if (csrWr.adrs == videoPkg::lpAdrsCtrl)
			begin
				if (imgHold && !csrWr.wd[0])
					expectFe = 1'b1;
				imgHold = csrWr.wd[0];
				imgGate = csrWr.wd[1];
			end
			if (csrWr.adrs == videoPkg::lpAdrsTft)
				imgTft = '{data: csrWr.wd[7:0], rst: csrWr.wd[8], wr: csrWr.wd[9],
					rd: csrWr.wd[10], rs: csrWr.wd[11], cs: csrWr.wd[12]};
			if (csrWr.adrs == videoPkg::lpAdrsBack)
				imgBack = csrWr.wd[23:0];
			for (int i = 0; i < videoPkg::lpSquareNum; i++)
			begin
				if (csrWr.adrs == videoPkg::lpAdrsColorBase + i)
					imgSq[i].color = csrWr.wd[23:0];
				if (csrWr.adrs == videoPkg::lpAdrsBoundBase + i)
					{imgSq[i].under, imgSq[i].top, imgSq[i].right, imgSq[i].left} = csrWr.wd;
			end
		end
	endtask

	// Sampled mid cycle where every output is settled
	always @(negedge iVCLK)
	begin
		if (iVRST)
		begin
			imgSq = '0;
			imgBack = '0;
			imgTft = '{data: 8'd0, rst: 1'b1, wr: 1'b0, rd: 1'b0, rs: 1'b0, cs: 1'b1};
			imgGate = 1'b0;
			imgHold = 1'b0;
			resetAge = 0;
			holdAge = 0;
			hCur = 0;
			vCur = 0;
			lineCnt = 0;
			hsLen = 0;
			vsLen = 0;
			trackValid = 1'b0;
			expectFe = 1'b0;
			deLast = 1'b0;
			hsLast = 1'b0;
			vsLast = 1'b0;
			rdPend = 1'b0;
			rdExpQ = '0;
		end
		else
		begin
			resetAge++;
			checkPins;
			checkRaster;
			applyWrite;
		end
	end

endmodule

/* test/videoTxTb.sv */
//------------------------------
// Video transmitter testbench
// Register table, frame runs and watchdog
//------------------------------
`timescale 1ns/1ps

module videoTxTb;

	logic iVCLK;
	logic iVRST;
	videoPkg::csrWriteT csrWr;
	videoPkg::csrAdrsT csrRdAdrs;
	videoPkg::csrDataT csrRd;
	videoPkg::colorT videoDq;
	logic videoHs;
	logic videoVs;
	logic videoDe;
	logic videoFe;
	logic videoRst;
	logic videoWr;
	logic videoRd;
	logic videoRs;
	logic videoCs;

	// Readback request to the checker
	logic rdReq;
	videoPkg::csrDataT rdExp;
	logic [127:0] curName;
	int errCount;
	int checkCount;
	int failTests;

	//------------------------------
	// Stimulus table
	//------------------------------
	// One entry per test, writes kept flat with a first index and a count
	logic [127:0] tName[$];
	int tWrFirst[$];
	int tWrNum[$];
	int tIdle[$];
	int tFrames[$];
	videoPkg::csrAdrsT tRdAdrs[$];
	videoPkg::csrDataT tRdExp[$];
	videoPkg::csrAdrsT wrAdrs[$];
	videoPkg::csrDataT wrData[$];
	int wrOpen;
	logic tableReady = 1'b0;
	logic [31:0] lfsrState;

	// x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | int'(lfsrState[0]);
		end
		return v;
	endfunction

	task automatic addWrite(input videoPkg::csrAdrsT adrs, input videoPkg::csrDataT data);
		wrAdrs.push_back(adrs);
		wrData.push_back(data);
	endtask

	// Closes the entry over the writes added since the last one
	task automatic addTest(input logic [127:0] name, input int idle, input int frames,
			input videoPkg::csrAdrsT rdAdrs, input videoPkg::csrDataT rdWord);
		tName.push_back(name);
		tWrFirst.push_back(wrOpen);
		tWrNum.push_back(wrAdrs.size() - wrOpen);
		tIdle.push_back(idle);
		tFrames.push_back(frames);
		tRdAdrs.push_back(rdAdrs);
		tRdExp.push_back(rdWord);
		wrOpen = wrAdrs.size();
	endtask

	task automatic buildTable;
		int left;
		int right;
		int top;
		int under;
		videoPkg::csrDataT bound;
		wrOpen = 0;
		addTest("resetState", 0, 2, videoPkg::lpAdrsCtrl, 32'h0);
		addWrite(videoPkg::lpAdrsBack, 32'h00123456);
		addTest("regReadback", 0, 1, videoPkg::lpAdrsBack, 32'h00123456);
		addTest("unmapped", 0, 1, 8'h3F, 32'h0);
		// Three overlapping squares, bound word is under top right left
		addWrite(videoPkg::lpAdrsColorBase + 8'd0, 32'h00FF0000);
		addWrite(videoPkg::lpAdrsBoundBase + 8'd0, 32'h05010802);
		addWrite(videoPkg::lpAdrsColorBase + 8'd1, 32'h0000FF00);
		addWrite(videoPkg::lpAdrsBoundBase + 8'd1, 32'h07030C05);
		addWrite(videoPkg::lpAdrsColorBase + 8'd2, 32'h000000FF);
		addWrite(videoPkg::lpAdrsBoundBase + 8'd2, 32'h08061000);
		addTest("overlap", 0, 2, videoPkg::lpAdrsBoundBase + 8'd1, 32'h07030C05);
		addTest("colorReadback", 0, 1, videoPkg::lpAdrsColorBase + 8'd2, 32'h000000FF);
		// Random square 0 on top of the others
		left = randBits(4);
		right = left + randBits(3) + 1;
		top = randBits(3);
		under = top + randBits(2) + 1;
		bound = {under[7:0], top[7:0], right[7:0], left[7:0]};
		addWrite(videoPkg::lpAdrsColorBase + 8'd0, 32'h00A5C3E7);
		addWrite(videoPkg::lpAdrsBoundBase + 8'd0, bound);
		addTest("randomSquare", 0, 2, videoPkg::lpAdrsBoundBase + 8'd0, bound);
		// Data 5A with rst wr rs high, cs low
		addWrite(videoPkg::lpAdrsTft, 32'h00000B5A);
		addWrite(videoPkg::lpAdrsCtrl, 32'h00000002);
		addTest("tftGateOn", 0, 1, videoPkg::lpAdrsTft, 32'h00000B5A);
		// Data A5 with only rd high and the panel reset released
		addWrite(videoPkg::lpAdrsTft, 32'h000004A5);
		addTest("tftCmdChange", 0, 1, videoPkg::lpAdrsTft, 32'h000004A5);
		addWrite(videoPkg::lpAdrsCtrl, 32'h0);
		addWrite(videoPkg::lpAdrsTft, 32'h00001100);
		addTest("tftGateOff", 0, 1, videoPkg::lpAdrsCtrl, 32'h0);
		// Position status reads zero while held
		addWrite(videoPkg::lpAdrsCtrl, 32'h00000001);
		addTest("syncHold", 400, 0, videoPkg::lpAdrsStatus, 32'h0);
		addTest("holdCtrlRead", 0, 0, videoPkg::lpAdrsCtrl, 32'h1);
		addWrite(videoPkg::lpAdrsCtrl, 32'h0);
		addTest("holdRelease", 0, 2, videoPkg::lpAdrsCtrl, 32'h0);
	endtask

	//------------------------------
	// Test sequencing
	//------------------------------
	task automatic waitFrames(input int n);
		for (int f = 0; f < n; f++)
		begin
			@(negedge iVCLK);
			while (videoFe !== 1'b1)
				@(negedge iVCLK);
		end
	endtask

	task automatic runTest(input int t);
		int errBefore;
		errBefore = errCount;
		@(posedge iVCLK);
		curName <= tName[t];
		for (int w = tWrFirst[t]; w < tWrFirst[t] + tWrNum[t]; w++)
		begin
			csrWr <= '{we: 1'b1, adrs: wrAdrs[w], wd: wrData[w]};
			@(posedge iVCLK);
		end
		csrWr <= '0;
		repeat (tIdle[t]) @(posedge iVCLK);
		csrRdAdrs <= tRdAdrs[t];
		rdReq <= 1'b1;
		rdExp <= tRdExp[t];
		@(posedge iVCLK);
		rdReq <= 1'b0;
		@(posedge iVCLK);
		waitFrames(tFrames[t]);
		@(posedge iVCLK);
		if (errCount == errBefore)
			$display("%s: ok", tName[t]);
		else
		begin
			failTests++;
			$display("%s: %0d errors", tName[t], errCount - errBefore);
		end
	endtask

	initial
	begin
		iVCLK = 1'b0;
		forever #10 iVCLK = ~iVCLK;
	end

	initial
	begin
		iVRST = 1'b1;
		csrWr = '0;
		csrRdAdrs = '0;
		rdReq = 1'b0;
		rdExp = '0;
		curName = "reset";
		failTests = 0;
		lfsrState = 32'h8390ba69;
		buildTable;
		tableReady = 1'b1;
		repeat (5) @(posedge iVCLK);
		iVRST <= 1'b0;
		for (int t = 0; t < tName.size(); t++)
			runTest(t);
		@(posedge iVCLK);
		$display("Tests run %0d, with errors %0d, checks %0d, errors %0d",
			tName.size(), failTests, checkCount, errCount);
		if (errCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// One frame of slack per test for the wait on fe
	initial
	begin
		int limit;
		wait (tableReady === 1'b1);
		limit = 1000;
		for (int t = 0; t < tName.size(); t++)
			limit += (tFrames[t] + 1) * videoPkg::lpHTotal * videoPkg::lpVTotal
				+ tIdle[t] + tWrNum[t] + 10;
		repeat (limit) @(posedge iVCLK);
		$display("Watchdog expired after %0d cycles, frames stopped arriving", limit);
		$display("Test failed");
		$finish;
	end

	videoTx DUT (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.csrWr(csrWr),          .csrRdAdrs(csrRdAdrs),      .csrRd(csrRd),
		.videoDq(videoDq),
		.videoHs(videoHs),      .videoVs(videoVs),
		.videoDe(videoDe),      .videoFe(videoFe),
		.videoRst(videoRst),    .videoWr(videoWr),          .videoRd(videoRd),
		.videoRs(videoRs),      .videoCs(videoCs)
	);

	videoTxChecker monitor (
		.iVCLK(iVCLK),          .iVRST(iVRST),
		.csrWr(csrWr),          .csrRd(csrRd),
		.rdReq(rdReq),          .rdExp(rdExp),              .testName(curName),
		.videoDq(videoDq),
		.videoHs(videoHs),      .videoVs(videoVs),
		.videoDe(videoDe),      .videoFe(videoFe),
		.videoRst(videoRst),    .videoWr(videoWr),          .videoRd(videoRd),
		.videoRs(videoRs),      .videoCs(videoCs),
		.errCount(errCount),    .checkCount(checkCount)
	);

endmodule

/* project.f */
common/videoPkg.sv
logic/videoCsr.sv
videoSync/videoSyncGen.sv
videoPaint/videoSquarePainter.sv
logic/videoOutMixer.sv
logic/videoTx.sv
test/videoTxChecker.sv
test/videoTxTb.sv

/* Makefile */
# Verilator build and run of the video transmitter testbench

TOP := videoTxTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)

# Pass only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
